//--- src/surfturf_pkg.sv
`default_nettype none

package surfturf_pkg;

    // channel and datapath sizes
    localparam int N_CHAN    = 4;
    localparam int TIME_W    = 15;
    localparam int BYTE_W    = 8;
    localparam int PKT_BYTES = 4;
    localparam int PKT_IDX_W = 2;

    // register bus geometry
    localparam int ADR_W        = 12;
    localparam int DAT_W        = 32;
    localparam int CORE_SEL_BIT = 11;
    localparam int CH_SEL_LSB   = 6;
    localparam int CH_SEL_W     = 3;

    // core register word addresses
    localparam logic [1:0] REG_ID      = 2'd0;
    localparam logic [1:0] REG_RUN     = 2'd1;
    localparam logic [1:0] REG_DISABLE = 2'd2;
    localparam logic [1:0] REG_SPLICED = 2'd3;

    // channel window word addresses
    localparam logic REG_EVCOUNT = 1'b0;
    localparam logic REG_DROPPED = 1'b1;

    localparam logic [DAT_W-1:0] CORE_ID = 32'h5354_0407;

    // kind of a mode1 byte, carried in tuser
    typedef enum logic [1:0] {
        KIND_RUNCMD  = 2'd0,
        KIND_TRIG_LO = 2'd1,
        KIND_TRIG_HI = 2'd2,
        KIND_NONE    = 2'd3
    } mode1_kind_t;

endpackage

`default_nettype wire

//--- src/run_control.sv
`default_nettype none

module run_control (
    input  logic                              sysclk_i,
    input  logic                              runrst_i,
    input  logic                              runstop_i,
    input  logic [surfturf_pkg::TIME_W-1:0]   trigtime_i,
    input  logic                              trigtime_valid_i,
    input  logic                              splice_trig_i,
    input  logic [surfturf_pkg::TIME_W-1:0]   splice_time_i,
    input  logic                              event_reset_req_i,
    output logic                              running_o,
    output logic                              trig_o,
    output logic [surfturf_pkg::TIME_W-1:0]   trig_time_o,
    output logic                              event_reset_o
);

    // run reset also starts the run
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            running_o <= 1'b1;
        end else if (runstop_i) begin
            running_o <= 1'b0;
        end
    end

    // merged trigger, external time has priority over the spliced one
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            trig_o <= 1'b0;
        end else begin
            trig_o <= running_o && (trigtime_valid_i || splice_trig_i);
        end
        trig_time_o <= trigtime_valid_i ? trigtime_i : splice_time_i;
    end

    assign event_reset_o = !running_o || event_reset_req_i;

endmodule

`default_nettype wire

//--- src/cmd_splice.sv
`default_nettype none

module cmd_splice (
    input  logic                              sysclk_i,
    input  logic                              runrst_i,
    input  logic                              sync_i,
    input  logic [surfturf_pkg::DAT_W-1:0]    command_i,
    input  logic [surfturf_pkg::BYTE_W-1:0]   mode1_tdata_i,
    input  logic [1:0]                        mode1_tuser_i,
    input  logic                              mode1_tvalid_i,
    output logic                              splice_trig_o,
    output logic [surfturf_pkg::TIME_W-1:0]   splice_time_o,
    output logic [surfturf_pkg::DAT_W-1:0]    spliced_o
);

    surfturf_pkg::mode1_kind_t                kind;
    logic [surfturf_pkg::BYTE_W-1:0]          time_lo_q;
    logic [1:0]                               runcmd_q;
    logic                                     runcmd_pend_q;
    logic                                     trig_pend_q;
    logic [surfturf_pkg::TIME_W-1:0]          pend_time;

    assign kind = surfturf_pkg::mode1_kind_t'(mode1_tuser_i);

    // time of a pending trigger, zero when none fired
    assign pend_time = trig_pend_q ? splice_time_o : '0;

    // low time byte waits for the matching high byte
    always_ff @(posedge sysclk_i) begin
        if (mode1_tvalid_i && kind == surfturf_pkg::KIND_TRIG_LO) begin
            time_lo_q <= mode1_tdata_i;
        end
        if (mode1_tvalid_i && kind == surfturf_pkg::KIND_TRIG_HI) begin
            splice_time_o <= {mode1_tdata_i[6:0], time_lo_q};
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            splice_trig_o <= 1'b0;
            runcmd_pend_q <= 1'b0;
            trig_pend_q <= 1'b0;
            runcmd_q <= 2'd0;
            spliced_o <= '0;
        end else begin
            splice_trig_o <= 1'b0;
            // sync consumes whatever is pending
            if (sync_i) begin
                spliced_o <= {runcmd_pend_q ? runcmd_q : 2'd0, trig_pend_q, pend_time,
                              command_i[13:0]};
                runcmd_pend_q <= 1'b0;
                trig_pend_q <= 1'b0;
            end
            if (mode1_tvalid_i) begin
                case (kind)
                    surfturf_pkg::KIND_RUNCMD: begin
                        runcmd_q <= mode1_tdata_i[1:0];
                        runcmd_pend_q <= 1'b1;
                    end
                    surfturf_pkg::KIND_TRIG_HI: begin
                        splice_trig_o <= 1'b1;
                        trig_pend_q <= 1'b1;
                    end
                    surfturf_pkg::KIND_TRIG_LO: begin
                    end
                    surfturf_pkg::KIND_NONE: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- src/surf_channel.sv
`default_nettype none

module surf_channel (
    input  logic                              sysclk_i,
    input  logic                              runrst_i,
    input  logic                              trig_i,
    input  logic [surfturf_pkg::TIME_W-1:0]   trig_time_i,
    input  logic                              event_reset_i,
    input  logic                              disable_i,
    input  logic [surfturf_pkg::BYTE_W-1:0]   sample_i,
    input  logic                              stb_i,
    input  logic                              adr_i,
    input  logic                              m_tready_i,
    output logic [surfturf_pkg::DAT_W-1:0]    dat_o,
    output logic                              ack_o,
    output logic [surfturf_pkg::BYTE_W-1:0]   m_tdata_o,
    output logic                              m_tvalid_o,
    output logic                              m_tlast_o
);

    logic                                     busy_q;
    logic [surfturf_pkg::PKT_IDX_W-1:0]       idx_q;
    logic [surfturf_pkg::TIME_W-1:0]          time_q;
    logic [surfturf_pkg::BYTE_W-1:0]          sample_q;
    logic [surfturf_pkg::BYTE_W-1:0]          count_q;
    logic [surfturf_pkg::DAT_W-1:0]           evcount_q;
    logic [surfturf_pkg::DAT_W-1:0]           evcount_next;
    logic [surfturf_pkg::DAT_W-1:0]           dropped_q;
    logic                                     accept;
    logic                                     drop;
    logic                                     last_byte;
    logic                                     xfer;

    assign accept = trig_i && !busy_q && !disable_i && !event_reset_i;
    assign drop = trig_i && busy_q && !disable_i;
    assign last_byte = (int'(idx_q) == surfturf_pkg::PKT_BYTES - 1);
    assign xfer = busy_q && m_tready_i;
    assign evcount_next = evcount_q + 1'b1;

    // byte sequencing, held under back-pressure
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            busy_q <= 1'b0;
            idx_q <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            idx_q <= '0;
        end else if (xfer) begin
            if (last_byte) begin
                busy_q <= 1'b0;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    // packet payload, snapshot taken at the trigger
    always_ff @(posedge sysclk_i) begin
        if (accept) begin
            time_q <= trig_time_i;
            sample_q <= sample_i;
            count_q <= evcount_next[surfturf_pkg::BYTE_W-1:0];
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (runrst_i || event_reset_i) begin
            evcount_q <= '0;
            dropped_q <= '0;
        end else begin
            if (accept) begin
                evcount_q <= evcount_next;
            end
            if (drop) begin
                dropped_q <= dropped_q + 1'b1;
            end
        end
    end

    always_comb begin
        case (idx_q)
            2'd0: m_tdata_o = time_q[7:0];
            2'd1: m_tdata_o = {1'b0, time_q[14:8]};
            2'd2: m_tdata_o = sample_q;
            default: m_tdata_o = count_q;
        endcase
    end

    assign m_tvalid_o = busy_q;
    assign m_tlast_o = busy_q && last_byte;

    // register window, read only
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= stb_i && !ack_o;
        end
    end

    always_ff @(posedge sysclk_i) begin
        case (adr_i)
            surfturf_pkg::REG_EVCOUNT: dat_o <= evcount_q;
            surfturf_pkg::REG_DROPPED: dat_o <= dropped_q;
        endcase
    end

endmodule

`default_nettype wire

//--- src/surfturf_regs.sv
`default_nettype none

module surfturf_regs (
    input  logic                              sysclk_i,
    input  logic                              runrst_i,
    input  logic                              stb_i,
    input  logic                              we_i,
    input  logic [1:0]                        adr_i,
    input  logic [surfturf_pkg::DAT_W-1:0]    dat_i,
    input  logic                              running_i,
    input  logic [surfturf_pkg::DAT_W-1:0]    spliced_i,
    input  logic                              sync_i,
    output logic [surfturf_pkg::DAT_W-1:0]    dat_o,
    output logic                              ack_o,
    output logic                              event_reset_req_o,
    output logic [surfturf_pkg::N_CHAN-1:0]   disable_o
);

    logic                                     wr;
    logic                                     sync_d;
    logic [surfturf_pkg::DAT_W-1:0]           spliced_q;

    // one write per access, the second stb cycle is the ack cycle
    assign wr = stb_i && we_i && !ack_o;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            ack_o <= 1'b0;
            event_reset_req_o <= 1'b0;
            disable_o <= '0;
        end else begin
            ack_o <= stb_i && !ack_o;
            event_reset_req_o <= wr && adr_i == surfturf_pkg::REG_RUN && dat_i[0];
            if (wr && adr_i == surfturf_pkg::REG_DISABLE) begin
                disable_o <= dat_i[surfturf_pkg::N_CHAN-1:0];
            end
        end
    end

    // splicer output settles the cycle after sync
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            sync_d <= 1'b0;
            spliced_q <= '0;
        end else begin
            sync_d <= sync_i;
            if (sync_d) begin
                spliced_q <= spliced_i;
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        case (adr_i)
            surfturf_pkg::REG_ID:      dat_o <= surfturf_pkg::CORE_ID;
            surfturf_pkg::REG_RUN:     dat_o <= {{(surfturf_pkg::DAT_W-1){1'b0}}, running_i};
            surfturf_pkg::REG_DISABLE: begin
                dat_o <= {{(surfturf_pkg::DAT_W-surfturf_pkg::N_CHAN){1'b0}}, disable_o};
            end
            surfturf_pkg::REG_SPLICED: dat_o <= spliced_q;
        endcase
    end

endmodule

`default_nettype wire

//--- src/surfturf_wrapper.sv
`default_nettype none

module surfturf_wrapper (
    input  logic                                             sysclk_i,
    input  logic                                             runrst_i,
    input  logic                                             runstop_i,
    input  logic                                             sync_i,
    input  logic [surfturf_pkg::TIME_W-1:0]                  trigtime_i,
    input  logic                                             trigtime_valid_i,
    input  logic [surfturf_pkg::DAT_W-1:0]                   command_i,
    input  logic [surfturf_pkg::BYTE_W-1:0]                  mode1_tdata_i,
    input  logic [1:0]                                       mode1_tuser_i,
    input  logic                                             mode1_tvalid_i,
    input  logic [surfturf_pkg::N_CHAN*surfturf_pkg::BYTE_W-1:0] surf_dout_i,
    input  logic [surfturf_pkg::N_CHAN-1:0]                  m_tready_i,
    input  logic                                             wb_cyc_i,
    input  logic                                             wb_stb_i,
    input  logic                                             wb_we_i,
    input  logic [surfturf_pkg::ADR_W-1:0]                   wb_adr_i,
    input  logic [surfturf_pkg::DAT_W-1:0]                   wb_dat_i,
    output logic [surfturf_pkg::DAT_W-1:0]                   wb_dat_o,
    output logic                                             wb_ack_o,
    output logic [surfturf_pkg::DAT_W-1:0]                   surf_command_o,
    output logic [surfturf_pkg::N_CHAN*surfturf_pkg::BYTE_W-1:0] m_tdata_o,
    output logic [surfturf_pkg::N_CHAN-1:0]                  m_tvalid_o,
    output logic [surfturf_pkg::N_CHAN-1:0]                  m_tlast_o
);

    localparam int NC = surfturf_pkg::N_CHAN;
    localparam int BW = surfturf_pkg::BYTE_W;

    logic                                     running;
    logic                                     trig;
    logic [surfturf_pkg::TIME_W-1:0]          trig_time;
    logic                                     event_reset;
    logic                                     event_reset_req;
    logic                                     splice_trig;
    logic [surfturf_pkg::TIME_W-1:0]          splice_time;
    logic [NC-1:0]                            disable_mask;
    logic                                     bus_stb;
    logic                                     core_sel;
    logic [surfturf_pkg::CH_SEL_W-1:0]        ch_idx;
    logic                                     core_ack;
    logic [surfturf_pkg::DAT_W-1:0]           core_dat;
    logic [NC-1:0]                            ch_stb;
    logic [NC-1:0]                            ch_ack;
    logic [surfturf_pkg::DAT_W-1:0]           ch_dat [NC];
    logic                                     nomap_stb;
    logic                                     nomap_ack;

    // address decode
    assign bus_stb = wb_cyc_i && wb_stb_i;
    assign core_sel = wb_adr_i[surfturf_pkg::CORE_SEL_BIT];
    assign ch_idx = wb_adr_i[surfturf_pkg::CH_SEL_LSB +: surfturf_pkg::CH_SEL_W];
    assign nomap_stb = bus_stb && !core_sel && (int'(ch_idx) >= NC);

    // empty channel windows answer with zero
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            nomap_ack <= 1'b0;
        end else begin
            nomap_ack <= nomap_stb && !nomap_ack;
        end
    end

    always_comb begin
        wb_ack_o = nomap_ack;
        wb_dat_o = '0;
        if (core_sel) begin
            wb_ack_o = core_ack;
            wb_dat_o = core_dat;
        end else begin
            for (int k = 0; k < NC; k++) begin
                if (int'(ch_idx) == k) begin
                    wb_ack_o = ch_ack[k];
                    wb_dat_o = ch_dat[k];
                end
            end
        end
    end

    run_control u_run (
        .sysclk_i(sysclk_i), .runrst_i(runrst_i), .runstop_i(runstop_i),
        .trigtime_i(trigtime_i), .trigtime_valid_i(trigtime_valid_i),
        .splice_trig_i(splice_trig), .splice_time_i(splice_time),
        .event_reset_req_i(event_reset_req), .running_o(running), .trig_o(trig),
        .trig_time_o(trig_time), .event_reset_o(event_reset)
    );

    cmd_splice u_splice (
        .sysclk_i(sysclk_i), .runrst_i(runrst_i), .sync_i(sync_i), .command_i(command_i),
        .mode1_tdata_i(mode1_tdata_i), .mode1_tuser_i(mode1_tuser_i),
        .mode1_tvalid_i(mode1_tvalid_i), .splice_trig_o(splice_trig),
        .splice_time_o(splice_time), .spliced_o(surf_command_o)
    );

    surfturf_regs u_core (
        .sysclk_i(sysclk_i), .runrst_i(runrst_i), .stb_i(bus_stb && core_sel),
        .we_i(wb_we_i), .adr_i(wb_adr_i[1:0]), .dat_i(wb_dat_i), .running_i(running),
        .spliced_i(surf_command_o), .sync_i(sync_i), .dat_o(core_dat), .ack_o(core_ack),
        .event_reset_req_o(event_reset_req), .disable_o(disable_mask)
    );

    for (genvar gi = 0; gi < NC; gi++) begin : g_chan
        assign ch_stb[gi] = bus_stb && !core_sel && (int'(ch_idx) == gi);

        surf_channel u_chan (
            .sysclk_i(sysclk_i), .runrst_i(runrst_i), .trig_i(trig), .trig_time_i(trig_time),
            .event_reset_i(event_reset), .disable_i(disable_mask[gi]),
            .sample_i(surf_dout_i[gi*BW +: BW]), .stb_i(ch_stb[gi]), .adr_i(wb_adr_i[0]),
            .m_tready_i(m_tready_i[gi]), .dat_o(ch_dat[gi]), .ack_o(ch_ack[gi]),
            .m_tdata_o(m_tdata_o[gi*BW +: BW]), .m_tvalid_o(m_tvalid_o[gi]),
            .m_tlast_o(m_tlast_o[gi])
        );
    end

endmodule

`default_nettype wire

//--- tb/surfturf_asserts.sv
`default_nettype none

module surfturf_asserts (
    input  logic                                                 sysclk_i,
    input  logic                                                 runrst_i,
    input  logic                                                 cyc_i,
    input  logic                                                 stb_i,
    input  logic                                                 ack_i,
    input  logic [surfturf_pkg::N_CHAN*surfturf_pkg::BYTE_W-1:0] tdata_i,
    input  logic [surfturf_pkg::N_CHAN-1:0]                      tvalid_i,
    input  logic [surfturf_pkg::N_CHAN-1:0]                      tready_i,
    input  logic [surfturf_pkg::N_CHAN-1:0]                      tlast_i
);

    localparam int BW = surfturf_pkg::BYTE_W;

    int fail_count = 0;

    // a slave acks only in the cycle after a strobe
    ack_after_stb: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        ack_i |-> $past(cyc_i && stb_i))
        else begin
            $error("bus ack without a strobe in the previous cycle");
            fail_count++;
        end

    last_with_valid: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        (tlast_i & ~tvalid_i) == '0)
        else begin
            $error("tlast high without tvalid");
            fail_count++;
        end

    for (genvar g = 0; g < surfturf_pkg::N_CHAN; g++) begin : g_hold
        // held byte must not move under back-pressure
        data_held: assert property (@(posedge sysclk_i) disable iff (runrst_i)
            tvalid_i[g] && !tready_i[g] |=> $stable(tdata_i[g*BW +: BW]))
            else begin
                $error("tdata changed while stalled");
                fail_count++;
            end
    end

endmodule

bind surfturf_wrapper surfturf_asserts asserts0 (
    .sysclk_i(sysclk_i), .runrst_i(runrst_i), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i),
    .ack_i(wb_ack_o), .tdata_i(m_tdata_o), .tvalid_i(m_tvalid_o), .tready_i(m_tready_i),
    .tlast_i(m_tlast_o)
);

`default_nettype wire

//--- tb/surfturf_checker.sv
`default_nettype none

module surfturf_checker (
    input  logic                                                 sysclk_i,
    input  logic                                                 we_i,
    input  logic                                                 ack_i,
    input  logic [surfturf_pkg::DAT_W-1:0]                       rdat_i,
    input  logic                                                 sync_i,
    input  logic [surfturf_pkg::DAT_W-1:0]                       cmd_i,
    input  logic [surfturf_pkg::N_CHAN*surfturf_pkg::BYTE_W-1:0] tdata_i,
    input  logic [surfturf_pkg::N_CHAN-1:0]                      tvalid_i,
    input  logic [surfturf_pkg::N_CHAN-1:0]                      tready_i,
    input  logic [surfturf_pkg::N_CHAN-1:0]                      tlast_i
);

    localparam int NC = surfturf_pkg::N_CHAN;

    // expected bytes per channel, tlast in bit 8
    logic [8:0]  byte_q [NC][$];
    logic [31:0] read_q [$];
    logic [31:0] cmd_q [$];
    logic        sync_d = 1'b0;
    int          errors = 0;
    int          checks = 0;

    task automatic expect_packet(input int ch, input logic [31:0] pkt);
        for (int i = 0; i < 4; i++) begin
            byte_q[ch].push_back({i == 3, pkt[31 - 8*i -: 8]});
        end
    endtask

    task automatic expect_read(input logic [31:0] val);
        read_q.push_back(val);
    endtask

    task automatic expect_command(input logic [31:0] val);
        cmd_q.push_back(val);
    endtask

    always @(posedge sysclk_i) begin
        logic [8:0]  want;
        logic [31:0] word;
        for (int c = 0; c < NC; c++) begin
            if (tvalid_i[c] && tready_i[c]) begin
                if (byte_q[c].size() == 0) begin
                    errors++;
                    $display("channel %0d sent a byte that no trigger asked for", c);
                end else begin
                    want = byte_q[c].pop_front();
                    checks++;
                    if ({tlast_i[c], tdata_i[c*8 +: 8]} !== want) begin
                        errors++;
                        $display("Fail %0t: ch%0d last/byte %h, expected %h", $time, c,
                                 {tlast_i[c], tdata_i[c*8 +: 8]}, want);
                    end
                end
            end
        end
        if (ack_i && !we_i) begin
            if (read_q.size() == 0) begin
                errors++;
                $display("a bus read was acknowledged with no read pending");
            end else begin
                word = read_q.pop_front();
                checks++;
                if (rdat_i !== word) begin
                    errors++;
                    $display("Fail %0t: bus read %h, expected %h", $time, rdat_i, word);
                end
            end
        end
        // spliced word is valid the cycle after sync
        if (sync_d && cmd_q.size() != 0) begin
            word = cmd_q.pop_front();
            checks++;
            if (cmd_i !== word) begin
                errors++;
                $display("Fail %0t: spliced command %h, expected %h", $time, cmd_i, word);
            end
        end
        sync_d = sync_i;
    end

    task automatic report_leftovers();
        for (int c = 0; c < NC; c++) begin
            if (byte_q[c].size() != 0) begin
                errors++;
                $display("channel %0d never sent %0d expected bytes", c, byte_q[c].size());
            end
        end
        if (read_q.size() != 0 || cmd_q.size() != 0) begin
            errors++;
            $display("some bus reads or spliced commands were never seen");
        end
    endtask

endmodule

`default_nettype wire

//--- tb/tb_surfturf.sv
`default_nettype none

module tb_surfturf;

    localparam int NC      = surfturf_pkg::N_CHAN;
    localparam int N_TRIGS = 12;
    localparam int LIMIT   = 40 * N_TRIGS + 2000;

    logic                 sysclk_i;
    logic                 runrst_i;
    logic                 runstop_i;
    logic                 sync_i;
    logic [14:0]          trigtime_i;
    logic                 trigtime_valid_i;
    logic [31:0]          command_i;
    logic [7:0]           mode1_tdata_i;
    logic [1:0]           mode1_tuser_i;
    logic                 mode1_tvalid_i;
    logic [NC*8-1:0]      surf_dout_i;
    logic [NC-1:0]        m_tready_i;
    logic                 wb_cyc_i;
    logic                 wb_stb_i;
    logic                 wb_we_i;
    logic [11:0]          wb_adr_i;
    logic [31:0]          wb_dat_i;
    logic [31:0]          wb_dat_o;
    logic                 wb_ack_o;
    logic [31:0]          surf_command_o;
    logic [NC*8-1:0]      m_tdata_o;
    logic [NC-1:0]        m_tvalid_o;
    logic [NC-1:0]        m_tlast_o;

    integer               seed = 67107;
    logic                 rnd_ready = 1'b0;
    logic [NC-1:0]        ready_fixed = '1;
    logic [7:0]           sample [NC];
    logic [31:0]          ev [NC];
    logic [14:0]          t5;
    logic [31:0]          word;
    int                   total;

    surfturf_wrapper dut0 (.*);

    surfturf_checker chk0 (
        .sysclk_i(sysclk_i), .we_i(wb_we_i), .ack_i(wb_ack_o), .rdat_i(wb_dat_o),
        .sync_i(sync_i), .cmd_i(surf_command_o), .tdata_i(m_tdata_o), .tvalid_i(m_tvalid_o),
        .tready_i(m_tready_i), .tlast_i(m_tlast_o)
    );

    initial begin
        sysclk_i = 1'b0;
        forever #4 sysclk_i = ~sysclk_i;
    end

    // packet bytes in transfer order with the first byte in the top bits
    function automatic logic [31:0] ref_packet(input logic [14:0] t, input logic [7:0] s,
                                               input logic [7:0] cnt);
        return {t[7:0], 1'b0, t[14:8], s, cnt};
    endfunction

    function automatic logic [31:0] ref_spliced(input logic [1:0] cmd, input logic cmd_valid,
                                                input logic fired, input logic [14:0] t,
                                                input logic [31:0] command);
        return {cmd_valid ? cmd : 2'd0, fired, fired ? t : 15'd0, command[13:0]};
    endfunction

    function automatic logic [11:0] core_adr(input logic [1:0] r);
        return {1'b1, 9'd0, r};
    endfunction

    function automatic logic [11:0] chan_adr(input int ch, input logic r);
        return {3'b000, 3'(ch), 5'd0, r};
    endfunction

    task automatic bus_cycle(input logic we, input logic [11:0] adr, input logic [31:0] dat);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        @(posedge sysclk_i);
        while (!wb_ack_o) @(posedge sysclk_i);
        #1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        @(posedge sysclk_i);
        #1;
    endtask

    task automatic bus_read_check(input logic [11:0] adr, input logic [31:0] want);
        chk0.expect_read(want);
        bus_cycle(1'b0, adr, 32'd0);
    endtask

    task automatic set_samples();
        for (int c = 0; c < NC; c++) begin
            sample[c] = 8'($random(seed));
            surf_dout_i[c*8 +: 8] = sample[c];
        end
    endtask

    task automatic expect_packets(input logic [14:0] t, input logic [NC-1:0] acc);
        for (int c = 0; c < NC; c++) begin
            if (acc[c]) begin
                ev[c] = ev[c] + 1;
                chk0.expect_packet(c, ref_packet(t, sample[c], ev[c][7:0]));
            end
        end
    endtask

    task automatic ext_trigger(input logic [14:0] t, input logic [NC-1:0] acc);
        set_samples();
        trigtime_i = t;
        trigtime_valid_i = 1'b1;
        expect_packets(t, acc);
        @(posedge sysclk_i);
        #1;
        trigtime_valid_i = 1'b0;
    endtask

    task automatic mode1_trigger(input logic [14:0] t);
        set_samples();
        mode1_tvalid_i = 1'b1;
        mode1_tuser_i = surfturf_pkg::KIND_TRIG_LO;
        mode1_tdata_i = t[7:0];
        @(posedge sysclk_i);
        #1;
        mode1_tuser_i = surfturf_pkg::KIND_TRIG_HI;
        mode1_tdata_i = {1'b0, t[14:8]};
        expect_packets(t, '1);
        @(posedge sysclk_i);
        #1;
        mode1_tvalid_i = 1'b0;
        mode1_tuser_i = surfturf_pkg::KIND_NONE;
    endtask

    // first byte shows up two cycles after the trigger input
    task automatic wait_idle(input logic [NC-1:0] mask);
        repeat (3) @(posedge sysclk_i);
        while ((m_tvalid_o & mask) != '0) @(posedge sysclk_i);
        #1;
    endtask

    task automatic clear_counts();
        for (int c = 0; c < NC; c++) begin
            ev[c] = 32'd0;
        end
    endtask

    initial begin
        forever begin
            @(posedge sysclk_i);
            #1;
            m_tready_i = rnd_ready ? 4'($random(seed)) : ready_fixed;
        end
    end

    initial begin
        repeat (LIMIT) @(posedge sysclk_i);
        $display("timeout after %0d cycles, the tests did not complete", LIMIT);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        runrst_i = 1'b1;
        runstop_i = 1'b0;
        sync_i = 1'b0;
        trigtime_i = '0;
        trigtime_valid_i = 1'b0;
        command_i = '0;
        mode1_tdata_i = '0;
        mode1_tuser_i = surfturf_pkg::KIND_NONE;
        mode1_tvalid_i = 1'b0;
        surf_dout_i = '0;
        m_tready_i = '1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        clear_counts();
        repeat (8) @(posedge sysclk_i);
        #1;
        runrst_i = 1'b0;

        // register map after reset
        bus_read_check(core_adr(surfturf_pkg::REG_ID), surfturf_pkg::CORE_ID);
        bus_read_check(core_adr(surfturf_pkg::REG_RUN), 32'd1);
        bus_read_check(chan_adr(5, 1'b0), 32'd0);

        // spaced triggers under random back-pressure
        rnd_ready = 1'b1;
        repeat (6) begin
            ext_trigger(15'($random(seed)), '1);
            wait_idle('1);
        end
        rnd_ready = 1'b0;

        // ch0 and ch1 stall on their first packet and ch1 is disabled before the next trigger
        ready_fixed = 4'b1100;
        ext_trigger(15'($random(seed)), '1);
        wait_idle(4'b1100);
        bus_cycle(1'b1, core_adr(surfturf_pkg::REG_DISABLE), 32'd2);
        bus_read_check(core_adr(surfturf_pkg::REG_DISABLE), 32'd2);
        ext_trigger(15'($random(seed)), 4'b1100);
        wait_idle(4'b1100);
        bus_read_check(chan_adr(0, surfturf_pkg::REG_DROPPED), 32'd1);
        bus_read_check(chan_adr(1, surfturf_pkg::REG_DROPPED), 32'd0);
        ready_fixed = '1;
        wait_idle('1);
        // a disabled idle channel ignores the trigger
        ext_trigger(15'($random(seed)), 4'b1101);
        wait_idle('1);
        bus_read_check(chan_adr(1, surfturf_pkg::REG_EVCOUNT), ev[1]);
        bus_cycle(1'b1, core_adr(surfturf_pkg::REG_DISABLE), 32'd0);

        // stopped run ignores triggers and holds counters at zero
        runstop_i = 1'b1;
        @(posedge sysclk_i);
        #1;
        runstop_i = 1'b0;
        clear_counts();
        ext_trigger(15'($random(seed)), '0);
        repeat (8) @(posedge sysclk_i);
        #1;
        bus_read_check(chan_adr(0, surfturf_pkg::REG_EVCOUNT), 32'd0);
        bus_read_check(core_adr(surfturf_pkg::REG_RUN), 32'd0);
        runrst_i = 1'b1;
        repeat (2) @(posedge sysclk_i);
        #1;
        runrst_i = 1'b0;
        ext_trigger(15'($random(seed)), '1);
        wait_idle('1);
        bus_read_check(chan_adr(2, surfturf_pkg::REG_EVCOUNT), 32'd1);
        bus_cycle(1'b1, core_adr(surfturf_pkg::REG_RUN), 32'd1);
        clear_counts();
        bus_read_check(chan_adr(2, surfturf_pkg::REG_EVCOUNT), 32'd0);

        // trigger and run command over mode1 followed by a sync
        t5 = 15'($random(seed));
        mode1_trigger(t5);
        wait_idle('1);
        mode1_tvalid_i = 1'b1;
        mode1_tuser_i = surfturf_pkg::KIND_RUNCMD;
        mode1_tdata_i = 8'h02;
        @(posedge sysclk_i);
        #1;
        mode1_tvalid_i = 1'b0;
        mode1_tuser_i = surfturf_pkg::KIND_NONE;
        command_i = $random(seed);
        word = ref_spliced(2'd2, 1'b1, 1'b1, t5, command_i);
        chk0.expect_command(word);
        sync_i = 1'b1;
        @(posedge sysclk_i);
        #1;
        sync_i = 1'b0;
        repeat (2) @(posedge sysclk_i);
        #1;
        bus_read_check(core_adr(surfturf_pkg::REG_SPLICED), word);

        repeat (4) @(posedge sysclk_i);
        #1;
        chk0.report_leftovers();
        total = chk0.errors + dut0.asserts0.fail_count;
        $display("checks %0d, checker errors %0d, assertion failures %0d",
                 chk0.checks, chk0.errors, dut0.asserts0.fail_count);
        if (total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
src/surfturf_pkg.sv
src/run_control.sv
src/cmd_splice.sv
src/surf_channel.sv
src/surfturf_regs.sv
src/surfturf_wrapper.sv
tb/surfturf_asserts.sv
tb/surfturf_checker.sv
tb/tb_surfturf.sv

//--- Makefile
TOP := tb_surfturf

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP) +verilator+error+limit+1000)"; echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir
